//--- flist.f
common/sq_pkg.sv
hdl/store_dispatch.sv
hdl/store_agu.sv
store_queue/store_queue.sv
hdl/store_retire.sv
hdl/store_unit_top.sv
verification/store_unit_tb.sv

//--- Makefile
# Verilator build and run for the store unit testbench

VERILATOR ?= verilator
TOP       ?= store_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides the result
run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/store_unit_tb.sv
// Store unit testbench
// Table-driven stimulus with a model queue of accepted stores, checked every cycle

`timescale 1ns/1ps

module store_unit_tb;

    localparam int lanes        = 2;
    localparam int agu_latency  = 2;
    localparam int period       = 20;
    localparam int reset_cycles = 5;
    localparam int pool_size    = 64;
    localparam int drain_cycles = agu_latency + sq_pkg::sq_depth + 4;

    typedef sq_pkg::store_decode_t [lanes-1:0] lane_group_t;

    // One table row drives one cycle
    typedef struct packed {
        logic [lanes-1:0]  mask;
        logic [7:0]        src;
        sq_pkg::sq_count_t commit;
        logic              flush;
        logic              stall;
    } row_t;

    // Store expected on the cache port, with its dispatch cycle
    typedef struct packed {
        sq_pkg::store_write_t wr;
        int                   cycle;
    } model_entry_t;

    logic                 clock;
    logic                 rst;
    lane_group_t          decode_lanes;
    sq_pkg::sq_count_t    commit_count;
    logic                 mispredict;
    logic                 dispatch_stall;
    sq_pkg::sq_count_t    free_slots;
    logic                 unexecuted_store;
    logic                 cache_write_valid;
    sq_pkg::store_write_t cache_write;

    row_t         rows [$];
    lane_group_t  lane_pool [pool_size];
    model_entry_t model_q [$];
    logic         table_loaded;
    int           seed;
    int           errors;
    int           checks;
    int           writes;
    int           commits;
    int           last_accept;
    int           last_flush;

    store_unit_top DUT (
        .clock             (clock),
        .rst               (rst),
        .decode_lanes      (decode_lanes),
        .commit_count      (commit_count),
        .mispredict        (mispredict),
        .dispatch_stall    (dispatch_stall),
        .free_slots        (free_slots),
        .unexecuted_store  (unexecuted_store),
        .cache_write_valid (cache_write_valid),
        .cache_write       (cache_write)
    );

    initial clock = 1'b0;
    always #(period/2) clock = ~clock;

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_write(input string name, input sq_pkg::store_write_t got,
                               input sq_pkg::store_write_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input sq_pkg::sq_count_t got,
                               input sq_pkg::sq_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ==============================
    // Stimulus table
    // ==============================

    // Negative src means the row uses its own random lanes
    task automatic add_row(input logic [lanes-1:0] mask, input int src, input int commit,
                           input logic flush, input logic stall);
        row_t row;
        row.mask   = mask;
        row.src    = (src < 0) ? 8'(rows.size()) : 8'(src);
        row.commit = sq_pkg::sq_count_t'(commit);
        row.flush  = flush;
        row.stall  = stall;
        rows.push_back(row);
    endtask

    task automatic add_idle(input int n);
        for (int i = 0; i < n; i++) begin
            add_row('0, -1, 0, 1'b0, 1'b0);
        end
    endtask

    task automatic build_table();
        // Fill the queue, upper lane alone gets packed down
        add_row(2'b11, -1, 0, 1'b0, 1'b0);
        add_row(2'b01, -1, 0, 1'b0, 1'b0);
        add_row(2'b10, -1, 0, 1'b0, 1'b0);
        add_row(2'b11, -1, 0, 1'b0, 1'b0);
        add_idle(1);
        add_row(2'b11, -1, 0, 1'b0, 1'b0);
        // Full queue turns groups away until commits free room
        add_row(2'b11, -1, 0, 1'b0, 1'b1);
        add_row(2'b00, -1, 2, 1'b0, 1'b0);
        add_row(2'b01, -1, 0, 1'b0, 1'b1);
        add_idle(1);
        // Row 6 presented again
        add_row(2'b11, 6, 0, 1'b0, 1'b0);
        // Commit all eight and drain
        add_row(2'b00, -1, 8, 1'b0, 1'b0);
        add_idle(9);
        // Commit in the same row as the dispatch
        add_row(2'b01, -1, 1, 1'b0, 1'b0);
        add_idle(4);
        add_row(2'b11, -1, 0, 1'b0, 1'b0);
        add_row(2'b01, -1, 0, 1'b0, 1'b0);
        add_row(2'b00, -1, 1, 1'b0, 1'b0);
        add_idle(2);
        // Uncommitted stores, two still in the AGU, then a flush
        add_row(2'b11, -1, 0, 1'b0, 1'b0);
        add_row(2'b00, -1, 0, 1'b1, 1'b0);
        add_idle(1);
        add_row(2'b11, -1, 2, 1'b0, 1'b0);
        add_idle(6);
    endtask

    task automatic fill_lane_pool();
        int v;
        for (int r = 0; r < pool_size; r++) begin
            for (int i = 0; i < lanes; i++) begin
                lane_pool[r][i].valid  = 1'b0;
                lane_pool[r][i].base   = $random(seed);
                v                      = $random(seed);
                lane_pool[r][i].offset = v[11:0];
                lane_pool[r][i].data   = $random(seed);
            end
        end
    endtask

    function automatic lane_group_t lanes_for(input row_t row);
        lane_group_t group;
        group = lane_pool[int'(row.src)];
        for (int i = 0; i < lanes; i++) begin
            group[i].valid = row.mask[i];
        end
        return group;
    endfunction

    // Base plus the signed 12-bit immediate
    function automatic sq_pkg::addr_t exp_addr(input sq_pkg::addr_t base,
                                               input logic signed [11:0] offset);
        int off;
        off = offset;
        return base + sq_pkg::addr_t'(off);
    endfunction

    // ==============================
    // One cycle: drive, then check
    // ==============================
    task automatic run_cycle(input row_t row, input int cyc);
        model_entry_t ent;
        lane_group_t  group;
        int           need;
        logic         exp_stall;
        logic         exp_unexec;
        @(posedge clock);
        decode_lanes <= lanes_for(row);
        commit_count <= row.commit;
        mispredict   <= row.flush;
        @(negedge clock);
        // Cache port first, its slot was freed at the edge that raised it
        if (cache_write_valid) begin
            writes++;
            if (model_q.size() == 0) begin
                errors++;
                $display("at %0t: cache write with no outstanding store", $time);
            end else begin
                ent = model_q.pop_front();
                check_write("cache_write", cache_write, ent.wr);
                // Executes at t + latency, releases next cycle, registered once more
                if (cyc - ent.cycle < agu_latency + 2) begin
                    errors++;
                    $display("at %0t: cache write came before its store executed", $time);
                end
            end
            if (writes > commits) begin
                errors++;
                $display("at %0t: more cache writes than commits", $time);
            end
        end
        check_count("free_slots", free_slots,
                    sq_pkg::sq_count_t'(sq_pkg::sq_depth - model_q.size()));
        need = 0;
        for (int i = 0; i < lanes; i++) begin
            need += int'(row.mask[i]);
        end
        exp_stall = (need > sq_pkg::sq_depth - model_q.size());
        if (exp_stall !== row.stall) begin
            errors++;
            $display("at %0t: table stall column disagrees with the queue model", $time);
        end
        check_flag("dispatch_stall", dispatch_stall, exp_stall);
        // High while the newest live store is still inside the AGU
        exp_unexec = (last_accept > last_flush) && (cyc - last_accept <= agu_latency);
        check_flag("unexecuted_store", unexecuted_store, exp_unexec);
        commits += int'(row.commit);
        if (!exp_stall && !row.flush && need > 0) begin
            group = lanes_for(row);
            for (int i = 0; i < lanes; i++) begin
                if (group[i].valid) begin
                    ent.wr.addr = exp_addr(group[i].base, group[i].offset);
                    ent.wr.data = group[i].data;
                    ent.cycle   = cyc;
                    model_q.push_back(ent);
                end
            end
            last_accept = cyc;
        end
        if (row.flush) begin
            model_q.delete();
            last_flush = cyc;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        row_t idle_row;
        seed         = 32'hde1da75d;
        errors       = 0;
        checks       = 0;
        writes       = 0;
        commits      = 0;
        last_accept  = -100;
        last_flush   = -1000;
        table_loaded = 1'b0;
        idle_row     = '0;
        rst          = 1'b1;
        decode_lanes = '0;
        commit_count = '0;
        mispredict   = 1'b0;
        fill_lane_pool();
        build_table();
        table_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        // Reset state
        check_count("free_slots", free_slots, sq_pkg::sq_count_t'(sq_pkg::sq_depth));
        check_flag("dispatch_stall", dispatch_stall, 1'b0);
        check_flag("unexecuted_store", unexecuted_store, 1'b0);
        check_flag("cache_write_valid", cache_write_valid, 1'b0);
        for (int r = 0; r < rows.size(); r++) begin
            run_cycle(rows[r], r);
        end
        for (int d = 0; d < drain_cycles; d++) begin
            run_cycle(idle_row, rows.size() + d);
        end
        if (model_q.size() != 0) begin
            errors++;
            $display("%0d accepted stores never reached the cache", model_q.size());
        end
        if (writes != commits) begin
            errors++;
            $display("cache write count does not match the commit count");
        end
        $display("store_unit_tb: %0d checks, %0d errors, %0d writes, %0d commits",
                 checks, errors, writes, commits);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table plus the drain
    initial begin
        wait (table_loaded === 1'b1);
        #(period * (reset_cycles + rows.size() + agu_latency + sq_pkg::sq_depth + 50));
        $display("watchdog expired before the table finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- hdl/store_unit_top.sv
// Store unit top level
// Dispatch, address unit, store queue and retire joined into one store path

`timescale 1ns/1ps

module store_unit_top #(
    parameter int dispatch_width = 2,
    parameter int agu_latency    = 2
) (
    input  logic                                       clock,
    input  logic                                       rst,
    input  sq_pkg::store_decode_t [dispatch_width-1:0] decode_lanes,
    input  sq_pkg::sq_count_t                          commit_count,
    input  logic                                       mispredict,
    output logic                                       dispatch_stall,
    output sq_pkg::sq_count_t                          free_slots,
    output logic                                       unexecuted_store,
    output logic                                       cache_write_valid,
    output sq_pkg::store_write_t                       cache_write
);

    // Dispatch to queue
    sq_pkg::sq_alloc_t [dispatch_width-1:0] alloc_lanes;
    sq_pkg::sq_count_t                      num_alloc;
    sq_pkg::sq_idx_t                        alloc_base;

    // Dispatch to AGU, AGU to queue
    sq_pkg::agu_req_t  [dispatch_width-1:0] agu_reqs;
    sq_pkg::sq_exec_t  [dispatch_width-1:0] exec_results;

    // Queue and retire handshake
    logic                                   head_ready;
    sq_pkg::store_write_t                   head_entry;
    logic                                   release_head;

    store_dispatch #(
        .dispatch_width (dispatch_width)
    ) u_dispatch (
        .decode_lanes   (decode_lanes),
        .free_slots     (free_slots),
        .alloc_base     (alloc_base),
        .alloc_lanes    (alloc_lanes),
        .num_alloc      (num_alloc),
        .agu_reqs       (agu_reqs),
        .dispatch_stall (dispatch_stall)
    );

    store_agu #(
        .dispatch_width (dispatch_width),
        .agu_latency    (agu_latency)
    ) u_agu (
        .clock        (clock),
        .rst          (rst),
        .mispredict   (mispredict),
        .agu_reqs     (agu_reqs),
        .exec_results (exec_results)
    );

    store_queue #(
        .dispatch_width (dispatch_width)
    ) u_queue (
        .clock            (clock),
        .rst              (rst),
        .mispredict       (mispredict),
        .alloc_lanes      (alloc_lanes),
        .num_alloc        (num_alloc),
        .exec_results     (exec_results),
        .release_head     (release_head),
        .alloc_base       (alloc_base),
        .free_slots       (free_slots),
        .head_ready       (head_ready),
        .head_entry       (head_entry),
        .unexecuted_store (unexecuted_store)
    );

    store_retire u_retire (
        .clock             (clock),
        .rst               (rst),
        .mispredict        (mispredict),
        .commit_count      (commit_count),
        .head_ready        (head_ready),
        .head_entry        (head_entry),
        .release_head      (release_head),
        .cache_write_valid (cache_write_valid),
        .cache_write       (cache_write)
    );

endmodule

//--- hdl/store_retire.sv
// Store retire
// Counts committed stores and drains the queue head to the cache write port

`timescale 1ns/1ps

module store_retire (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 mispredict,
    input  sq_pkg::sq_count_t    commit_count,
    input  logic                 head_ready,
    input  sq_pkg::store_write_t head_entry,
    output logic                 release_head,
    output logic                 cache_write_valid,
    output sq_pkg::store_write_t cache_write
);

    // Committed stores not yet sent to the cache
    sq_pkg::sq_count_t pending_q;

    // One store per cycle, only once committed and executed
    assign release_head = (pending_q != '0) && head_ready;

    // ==============================
    // Commit credits
    // ==============================
    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            pending_q <= '0;
        end else begin
            // Commits add, a release spends one
            pending_q <= pending_q + commit_count - sq_pkg::sq_count_t'(release_head);
        end
    end

    // ==============================
    // Cache port
    // ==============================
    always_ff @(posedge clock) begin
        if (rst) begin
            cache_write_valid <= 1'b0;
        end else begin
            cache_write_valid <= release_head;
        end
    end

    // Payload captured with the release
    always_ff @(posedge clock) begin
        if (release_head) begin
            cache_write <= head_entry;
        end
    end

    // ROB flushes only after all committed stores have drained
    a_flush_drained: assert property (@(posedge clock) disable iff (rst)
        $rose(mispredict) |-> (pending_q == '0));

endmodule

//--- store_queue/store_queue.sv
// Store queue
// Circular buffer of stores: allocates at the tail, records AGU write-back,
// and hands its head entry to retire in program order

`timescale 1ns/1ps

module store_queue #(
    parameter int dispatch_width = 2
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   mispredict,
    input  sq_pkg::sq_alloc_t [dispatch_width-1:0] alloc_lanes,
    input  sq_pkg::sq_count_t                      num_alloc,
    input  sq_pkg::sq_exec_t  [dispatch_width-1:0] exec_results,
    input  logic                                   release_head,
    output sq_pkg::sq_idx_t                        alloc_base,
    output sq_pkg::sq_count_t                      free_slots,
    output logic                                   head_ready,
    output sq_pkg::store_write_t                   head_entry,
    output logic                                   unexecuted_store
);

    // ==============================
    // Storage
    // ==============================

    // Per-entry state bits
    logic [sq_pkg::sq_depth-1:0] valid_q;
    logic [sq_pkg::sq_depth-1:0] executed_q;

    // Address and data, filled by write-back
    sq_pkg::store_write_t entry_q [sq_pkg::sq_depth];

    // Ring pointers and room counter
    sq_pkg::sq_idx_t   head_q;
    sq_pkg::sq_idx_t   tail_q;
    sq_pkg::sq_count_t free_q;

    // Next values of pointers and counter
    sq_pkg::sq_idx_t   head_next;
    sq_pkg::sq_idx_t   tail_next;
    sq_pkg::sq_count_t free_next;

    // ==============================
    // Pointer arithmetic
    // ==============================
    always_comb begin
        head_next = head_q;
        if (release_head) begin
            head_next = sq_pkg::sq_idx_t'((int'(head_q) + 1) % sq_pkg::sq_depth);
        end
        // Tail moves by the whole accepted group
        tail_next = sq_pkg::sq_idx_t'((int'(tail_q) + int'(num_alloc)) % sq_pkg::sq_depth);
        // Release frees one slot, dispatch takes num_alloc
        free_next = free_q + sq_pkg::sq_count_t'(release_head) - num_alloc;
    end

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            valid_q    <= '0;
            executed_q <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            free_q     <= sq_pkg::sq_count_t'(sq_pkg::sq_depth);
        end else begin
            // Head leaves the queue
            if (release_head) begin
                valid_q[head_q]    <= 1'b0;
                executed_q[head_q] <= 1'b0;
            end
            // New stores at the tail, lanes already compacted
            for (int i = 0; i < dispatch_width; i++) begin
                if (alloc_lanes[i].valid) begin
                    valid_q[sq_pkg::sq_idx_t'((int'(tail_q) + i) % sq_pkg::sq_depth)]
                        <= 1'b1;
                    executed_q[sq_pkg::sq_idx_t'((int'(tail_q) + i) % sq_pkg::sq_depth)]
                        <= 1'b0;
                end
            end
            // AGU results mark their slots executed
            for (int l = 0; l < dispatch_width; l++) begin
                if (exec_results[l].valid) begin
                    executed_q[exec_results[l].idx] <= 1'b1;
                end
            end
            head_q <= head_next;
            tail_q <= tail_next;
            free_q <= free_next;
        end
    end

    // Payload write from the AGU
    always_ff @(posedge clock) begin
        for (int l = 0; l < dispatch_width; l++) begin
            if (exec_results[l].valid) begin
                entry_q[exec_results[l].idx].addr <= exec_results[l].addr;
                entry_q[exec_results[l].idx].data <= exec_results[l].data;
            end
        end
    end

    // ==============================
    // Outputs
    // ==============================
    assign alloc_base = tail_q;
    assign free_slots = free_q;

    // Head may go once it has both address and data
    assign head_ready = valid_q[head_q] && executed_q[head_q];
    assign head_entry = entry_q[head_q];

    // Any store still waiting for its AGU result
    assign unexecuted_store = |(valid_q & ~executed_q);

    // Retire only pulls a head that is ready
    a_release_ready: assert property (@(posedge clock) disable iff (rst)
        release_head |-> head_ready);

    // Write-back always lands on a live entry
    for (genvar l = 0; l < dispatch_width; l++) begin : g_wb_chk
        a_wb_valid: assert property (@(posedge clock) disable iff (rst)
            exec_results[l].valid |-> valid_q[exec_results[l].idx]);
    end

endmodule

//--- hdl/store_agu.sv
// Store address unit
// Fixed-latency pipeline forming base plus offset and carrying data to the queue

`timescale 1ns/1ps

module store_agu #(
    parameter int dispatch_width = 2,
    parameter int agu_latency    = 2
) (
    input  logic                                  clock,
    input  logic                                  rst,
    input  logic                                  mispredict,
    input  sq_pkg::agu_req_t [dispatch_width-1:0] agu_reqs,
    output sq_pkg::sq_exec_t [dispatch_width-1:0] exec_results
);

    // Sign extension width for the offset
    localparam int ext_bits = $bits(sq_pkg::addr_t) - sq_pkg::offset_bits;

    // Address formed this cycle, captured by stage 0
    sq_pkg::sq_exec_t [dispatch_width-1:0] formed;

    // Stage registers, index 0 is the youngest group
    sq_pkg::sq_exec_t [dispatch_width-1:0] stage_q [agu_latency];

    // ==============================
    // Address formation
    // ==============================
    always_comb begin
        for (int l = 0; l < dispatch_width; l++) begin
            formed[l].valid = agu_reqs[l].valid;
            formed[l].idx   = agu_reqs[l].idx;
            // Base plus sign-extended 12-bit immediate
            formed[l].addr  = agu_reqs[l].base
                            + {{ext_bits{agu_reqs[l].offset[sq_pkg::offset_bits-1]}},
                               agu_reqs[l].offset};
            formed[l].data  = agu_reqs[l].data;
        end
    end

    // ==============================
    // Stage shift
    // ==============================
    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            // Squash every in-flight group, payload left as is
            for (int s = 0; s < agu_latency; s++) begin
                for (int l = 0; l < dispatch_width; l++) begin
                    stage_q[s][l].valid <= 1'b0;
                end
            end
        end else begin
            stage_q[0] <= formed;
            // Later stages only move the record along
            for (int s = 1; s < agu_latency; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    // Oldest stage writes back to the queue
    assign exec_results = stage_q[agu_latency-1];

    // Lanes of one write-back group must hit distinct queue slots
    for (genvar i = 0; i < dispatch_width; i++) begin : g_idx_chk_i
        for (genvar j = i + 1; j < dispatch_width; j++) begin : g_idx_chk_j
            a_distinct_idx: assert property (@(posedge clock) disable iff (rst)
                (exec_results[i].valid && exec_results[j].valid)
                    |-> (exec_results[i].idx != exec_results[j].idx));
        end
    end

endmodule

//--- hdl/store_dispatch.sv
// Store dispatch
// Compacts valid decode lanes, checks queue room and tags each store with its slot

`timescale 1ns/1ps

module store_dispatch #(
    parameter int dispatch_width = 2
) (
    input  sq_pkg::store_decode_t [dispatch_width-1:0] decode_lanes,
    input  sq_pkg::sq_count_t                          free_slots,
    input  sq_pkg::sq_idx_t                            alloc_base,
    output sq_pkg::sq_alloc_t     [dispatch_width-1:0] alloc_lanes,
    output sq_pkg::sq_count_t                          num_alloc,
    output sq_pkg::agu_req_t      [dispatch_width-1:0] agu_reqs,
    output logic                                       dispatch_stall
);

    // Compacted lanes before the room check
    sq_pkg::sq_alloc_t [dispatch_width-1:0] packed_alloc;
    sq_pkg::agu_req_t  [dispatch_width-1:0] packed_reqs;
    sq_pkg::sq_count_t                      num_valid;

    // ==============================
    // Lane compaction
    // ==============================
    always_comb begin
        sq_pkg::sq_count_t pos;
        pos          = '0;
        packed_alloc = '0;
        packed_reqs  = '0;
        // Walk lanes in order, each valid one lands on the next free low lane
        for (int i = 0; i < dispatch_width; i++) begin
            if (decode_lanes[i].valid) begin
                packed_alloc[pos].valid = 1'b1;
                packed_reqs[pos].valid  = 1'b1;
                // Slot is tail plus position, wrapped around the ring
                packed_reqs[pos].idx    = sq_pkg::sq_idx_t'(
                    (int'(alloc_base) + int'(pos)) % sq_pkg::sq_depth);
                packed_reqs[pos].base   = decode_lanes[i].base;
                packed_reqs[pos].offset = decode_lanes[i].offset;
                packed_reqs[pos].data   = decode_lanes[i].data;
                pos++;
            end
        end
        num_valid = pos;
    end

    // ==============================
    // Room check
    // ==============================

    // All-or-nothing: a group that does not fit takes no slot at all
    assign dispatch_stall = (num_valid > free_slots);

    // Stalled group is dropped here, decode presents it again
    assign num_alloc   = dispatch_stall ? '0 : num_valid;
    assign alloc_lanes = dispatch_stall ? '0 : packed_alloc;
    assign agu_reqs    = dispatch_stall ? '0 : packed_reqs;

endmodule

//--- common/sq_pkg.sv
// Store path package
// Queue sizing and the packed records passed between dispatch, AGU, queue and retire

package sq_pkg;

    // ==============================
    // Queue sizing
    // ==============================
    localparam int sq_depth = 8;

    // Offset field width of a decoded store
    localparam int offset_bits = 12;

    // Index into the queue, wraps at sq_depth
    typedef logic [$clog2(sq_depth)-1:0] sq_idx_t;

    // Occupancy count, 0 up to sq_depth inclusive
    typedef logic [$clog2(sq_depth+1)-1:0] sq_count_t;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // ==============================
    // Pipeline records
    // ==============================

    // One decode lane as seen by dispatch
    typedef struct packed {
        logic                          valid;
        addr_t                         base;
        logic signed [offset_bits-1:0] offset;
        data_t                         data;
    } store_decode_t;

    // Allocation into the queue; address and data follow from the AGU
    typedef struct packed {
        logic valid;
    } sq_alloc_t;

    // Request to the address unit, tagged with its queue slot
    typedef struct packed {
        logic                          valid;
        sq_idx_t                       idx;
        addr_t                         base;
        logic signed [offset_bits-1:0] offset;
        data_t                         data;
    } agu_req_t;

    // AGU write-back into the queue
    typedef struct packed {
        logic    valid;
        sq_idx_t idx;
        addr_t   addr;
        data_t   data;
    } sq_exec_t;

    // Data-cache write port payload
    typedef struct packed {
        addr_t addr;
        data_t data;
    } store_write_t;

endpackage
